//--- Bender.yml
package:
  name: tnoc_mem_subsystem

sources:
  - files:
      - src/tnoc_pkg.sv
      - src/tnoc_fifo.sv
      - src/tnoc_address_decoder.sv
      - src/tnoc_memory_target.sv
      - src/tnoc_response_merger.sv
      - src/tnoc_mem_subsystem.sv
  - target: test
    files:
      - verif/tnoc_mem_subsystem_assertions.sv
      - verif/tb_tnoc_mem_subsystem.sv

//--- flist.f
src/tnoc_pkg.sv
src/tnoc_fifo.sv
src/tnoc_address_decoder.sv
src/tnoc_memory_target.sv
src/tnoc_response_merger.sv
src/tnoc_mem_subsystem.sv
verif/tnoc_mem_subsystem_assertions.sv
verif/tb_tnoc_mem_subsystem.sv

//--- src/tnoc_address_decoder.sv
module tnoc_address_decoder #(
  parameter int REQ_FIFO_DEPTH = 4,
  parameter int TGT_FIFO_DEPTH = 2
) (
  input  logic                             clk,
  input  logic                             i_arst_n,
  input  logic                             i_req_valid,
  input  tnoc_pkg::tnoc_request_t          i_req,
  input  logic [tnoc_pkg::NUM_TARGETS-1:0] i_tgt_credit,
  input  logic                             i_ord_credit,
  output logic                             o_req_credit,
  output logic [tnoc_pkg::NUM_TARGETS-1:0] o_tgt_valid,
  output tnoc_pkg::tnoc_request_t          o_tgt_req,
  output logic                             o_ord_valid,
  output tnoc_pkg::tnoc_order_t            o_ord
);
  localparam int ORD_CREDITS = REQ_FIFO_DEPTH + tnoc_pkg::NUM_TARGETS * TGT_FIFO_DEPTH;
  localparam int TGT_CNT_W   = $clog2(TGT_FIFO_DEPTH + 1);
  localparam int ORD_CNT_W   = $clog2(ORD_CREDITS + 1);

  tnoc_pkg::tnoc_request_t head;
  logic                    head_empty;
  tnoc_pkg::node_id_t      head_node;
  logic                    head_decerr;
  logic                    tgt_ok;
  logic                    dispatch;
  logic [TGT_CNT_W-1:0]    tgt_cnt [tnoc_pkg::NUM_TARGETS];
  logic [ORD_CNT_W-1:0]    ord_cnt;

  tnoc_fifo #(
    .WIDTH ($bits(tnoc_pkg::tnoc_request_t)),
    .DEPTH (REQ_FIFO_DEPTH                 )
  ) u_req_fifo (
    .clk      (clk        ),
    .i_arst_n (i_arst_n   ),
    .i_push   (i_req_valid),
    .i_wdata  (i_req      ),
    .i_pop    (dispatch   ),
    .o_rdata  (head       ),
    .o_empty  (head_empty )
  );

  // ==========================================================
  // Address decode and dispatch
  // ==========================================================

  assign head_node   = head.addr[15:14];
  assign head_decerr = (head_node >= tnoc_pkg::node_id_t'(tnoc_pkg::NUM_TARGETS));
  assign tgt_ok      = head_decerr || (tgt_cnt[head_node] != '0);  // Region 3 needs no target
  assign dispatch    = !head_empty && (ord_cnt != '0) && tgt_ok;

  always_comb begin
    for (int k = 0; k < tnoc_pkg::NUM_TARGETS; k++) begin
      o_tgt_valid[k] = dispatch && !head_decerr && (head_node == tnoc_pkg::node_id_t'(k));
    end
  end

  assign o_tgt_req    = head;  // Shared by all targets and qualified by o_tgt_valid
  assign o_ord_valid  = dispatch;
  assign o_ord        = '{node: head_node, decerr: head_decerr, write: head.write, id: head.id};
  assign o_req_credit = dispatch;  // Slot in the input buffer frees on dispatch

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int k = 0; k < tnoc_pkg::NUM_TARGETS; k++) begin
        tgt_cnt[k] <= TGT_CNT_W'(TGT_FIFO_DEPTH);
      end
      ord_cnt <= ORD_CNT_W'(ORD_CREDITS);
    end else begin
      for (int k = 0; k < tnoc_pkg::NUM_TARGETS; k++) begin
        tgt_cnt[k] <= tgt_cnt[k] - TGT_CNT_W'(o_tgt_valid[k]) + TGT_CNT_W'(i_tgt_credit[k]);
      end
      ord_cnt <= ord_cnt - ORD_CNT_W'(dispatch) + ORD_CNT_W'(i_ord_credit);
    end
  end
endmodule

//--- src/tnoc_fifo.sv
module tnoc_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             i_arst_n,
  input  logic             i_push,
  input  logic [WIDTH-1:0] i_wdata,
  input  logic             i_pop,
  output logic [WIDTH-1:0] o_rdata,
  output logic             o_empty
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_wdata;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Depth need not be 2^n
      end
      if (i_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(i_push) - CNT_W'(i_pop);
    end
  end

  assign o_rdata = mem[rd_ptr];  // Head entry is visible without a pop
  assign o_empty = (count == '0);
endmodule

//--- src/tnoc_mem_subsystem.sv
module tnoc_mem_subsystem #(
  parameter int REQ_FIFO_DEPTH = 4,
  parameter int TGT_FIFO_DEPTH = 2,
  parameter int RSP_BUF_DEPTH  = 2,
  parameter int MEM_WORDS      = 16,
  parameter int RSP_CREDITS    = 2
) (
  input  logic                     clk,
  input  logic                     i_arst_n,
  input  logic                     i_req_valid,
  input  tnoc_pkg::tnoc_request_t  i_req,
  input  logic                     i_rsp_credit,
  output logic                     o_req_credit,
  output logic                     o_rsp_valid,
  output tnoc_pkg::tnoc_response_t o_rsp
);
  logic [tnoc_pkg::NUM_TARGETS-1:0] tgt_req_valid;
  tnoc_pkg::tnoc_request_t          tgt_req;
  logic [tnoc_pkg::NUM_TARGETS-1:0] tgt_req_credit;
  logic                             ord_valid;
  tnoc_pkg::tnoc_order_t            ord;
  logic                             ord_credit;
  logic [tnoc_pkg::NUM_TARGETS-1:0] tgt_rsp_valid;
  tnoc_pkg::tnoc_response_t         tgt_rsp [tnoc_pkg::NUM_TARGETS];
  logic [tnoc_pkg::NUM_TARGETS-1:0] tgt_rsp_credit;

  tnoc_address_decoder #(
    .REQ_FIFO_DEPTH (REQ_FIFO_DEPTH),
    .TGT_FIFO_DEPTH (TGT_FIFO_DEPTH)
  ) u_decoder (
    .clk          (clk           ),
    .i_arst_n     (i_arst_n      ),
    .i_req_valid  (i_req_valid   ),
    .i_req        (i_req         ),
    .i_tgt_credit (tgt_req_credit),
    .i_ord_credit (ord_credit    ),
    .o_req_credit (o_req_credit  ),
    .o_tgt_valid  (tgt_req_valid ),
    .o_tgt_req    (tgt_req       ),
    .o_ord_valid  (ord_valid     ),
    .o_ord        (ord           )
  );

  for (genvar k = 0; k < tnoc_pkg::NUM_TARGETS; k++) begin : g_target
    tnoc_memory_target #(
      .TGT_FIFO_DEPTH (TGT_FIFO_DEPTH),
      .RSP_BUF_DEPTH  (RSP_BUF_DEPTH ),
      .MEM_WORDS      (MEM_WORDS     )
    ) u_target (
      .clk          (clk              ),
      .i_arst_n     (i_arst_n         ),
      .i_req_valid  (tgt_req_valid[k] ),
      .i_req        (tgt_req          ),
      .i_rsp_credit (tgt_rsp_credit[k]),
      .o_req_credit (tgt_req_credit[k]),
      .o_rsp_valid  (tgt_rsp_valid[k] ),
      .o_rsp        (tgt_rsp[k]       )
    );
  end

  tnoc_response_merger #(
    .REQ_FIFO_DEPTH (REQ_FIFO_DEPTH),
    .TGT_FIFO_DEPTH (TGT_FIFO_DEPTH),
    .RSP_BUF_DEPTH  (RSP_BUF_DEPTH ),
    .RSP_CREDITS    (RSP_CREDITS   )
  ) u_merger (
    .clk              (clk           ),
    .i_arst_n         (i_arst_n      ),
    .i_ord_valid      (ord_valid     ),
    .i_ord            (ord           ),
    .i_tgt_rsp_valid  (tgt_rsp_valid ),
    .i_tgt_rsp        (tgt_rsp       ),
    .i_rsp_credit     (i_rsp_credit  ),
    .o_ord_credit     (ord_credit    ),
    .o_tgt_rsp_credit (tgt_rsp_credit),
    .o_rsp_valid      (o_rsp_valid   ),
    .o_rsp            (o_rsp         )
  );
endmodule

//--- src/tnoc_memory_target.sv
module tnoc_memory_target #(
  parameter int TGT_FIFO_DEPTH = 2,
  parameter int RSP_BUF_DEPTH  = 2,
  parameter int MEM_WORDS      = 16
) (
  input  logic                     clk,
  input  logic                     i_arst_n,
  input  logic                     i_req_valid,
  input  tnoc_pkg::tnoc_request_t  i_req,
  input  logic                     i_rsp_credit,
  output logic                     o_req_credit,
  output logic                     o_rsp_valid,
  output tnoc_pkg::tnoc_response_t o_rsp
);
  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = $clog2(RSP_BUF_DEPTH + 1);

  tnoc_pkg::tnoc_request_t head;
  logic                    head_empty;
  logic                    exec;
  logic [IDX_W-1:0]        word_idx;
  tnoc_pkg::data_t         rd_word;
  tnoc_pkg::data_t         mem [MEM_WORDS];
  logic [MEM_WORDS-1:0]    word_vld;
  logic [CNT_W-1:0]        rsp_cnt;

  tnoc_fifo #(
    .WIDTH ($bits(tnoc_pkg::tnoc_request_t)),
    .DEPTH (TGT_FIFO_DEPTH                 )
  ) u_req_fifo (
    .clk      (clk        ),
    .i_arst_n (i_arst_n   ),
    .i_push   (i_req_valid),
    .i_wdata  (i_req      ),
    .i_pop    (exec       ),
    .o_rdata  (head       ),
    .o_empty  (head_empty )
  );

  assign exec     = !head_empty && (rsp_cnt != '0);  // One request per cycle while credit lasts
  assign word_idx = IDX_W'((head.addr >> 2) % MEM_WORDS);
  assign rd_word  = word_vld[word_idx] ? mem[word_idx] : '0;  // Unwritten words read as zero

  always_ff @(posedge clk) begin
    if (exec && head.write) begin
      mem[word_idx] <= head.wdata;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      word_vld <= '0;
      rsp_cnt  <= CNT_W'(RSP_BUF_DEPTH);
    end else begin
      if (exec && head.write) begin
        word_vld[word_idx] <= 1'b1;
      end
      rsp_cnt <= rsp_cnt - CNT_W'(exec) + CNT_W'(i_rsp_credit);
    end
  end

  always_comb begin
    o_rsp.write = head.write;
    o_rsp.id    = head.id;
    o_rsp.resp  = tnoc_pkg::RESP_OKAY;
    o_rsp.rdata = head.write ? '0 : rd_word;
  end

  assign o_rsp_valid  = exec;  // Response leaves in the execute cycle
  assign o_req_credit = exec;
endmodule

//--- src/tnoc_pkg.sv
package tnoc_pkg;

  // ==========================================================
  // Field types
  // ==========================================================

  typedef logic [15:0] addr_t;    // Region in the top two bits and word index from bit 2
  typedef logic [31:0] data_t;
  typedef logic [3:0]  txn_id_t;  // Chosen by the initiator and returned as is
  typedef logic [1:0]  node_id_t;
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  localparam int NUM_TARGETS = 3;  // Regions at or above this value have no memory node

  // ==========================================================
  // Link payloads
  // ==========================================================

  typedef struct packed {
    logic    write;
    txn_id_t id;
    addr_t   addr;
    data_t   wdata;
  } tnoc_request_t;

  // One entry per dispatched request so responses can be put back in order
  typedef struct packed {
    node_id_t node;
    logic     decerr;
    logic     write;   // Needed to build the decode error response
    txn_id_t  id;
  } tnoc_order_t;

  typedef struct packed {
    logic    write;
    txn_id_t id;
    resp_t   resp;
    data_t   rdata;
  } tnoc_response_t;

endpackage

//--- src/tnoc_response_merger.sv
module tnoc_response_merger #(
  parameter int REQ_FIFO_DEPTH = 4,
  parameter int TGT_FIFO_DEPTH = 2,
  parameter int RSP_BUF_DEPTH  = 2,
  parameter int RSP_CREDITS    = 2
) (
  input  logic                             clk,
  input  logic                             i_arst_n,
  input  logic                             i_ord_valid,
  input  tnoc_pkg::tnoc_order_t            i_ord,
  input  logic [tnoc_pkg::NUM_TARGETS-1:0] i_tgt_rsp_valid,
  input  tnoc_pkg::tnoc_response_t         i_tgt_rsp [tnoc_pkg::NUM_TARGETS],
  input  logic                             i_rsp_credit,
  output logic                             o_ord_credit,
  output logic [tnoc_pkg::NUM_TARGETS-1:0] o_tgt_rsp_credit,
  output logic                             o_rsp_valid,
  output tnoc_pkg::tnoc_response_t         o_rsp
);
  localparam int ORD_DEPTH = REQ_FIFO_DEPTH + tnoc_pkg::NUM_TARGETS * TGT_FIFO_DEPTH;
  localparam int CNT_W     = $clog2(RSP_CREDITS + 1);

  typedef enum logic {
    MERGE_IDLE,
    MERGE_ISSUE
  } merge_state_e;

  merge_state_e                     state;
  tnoc_pkg::tnoc_order_t            ord_head;
  logic                             ord_empty;
  tnoc_pkg::tnoc_response_t         buf_head [tnoc_pkg::NUM_TARGETS];
  logic [tnoc_pkg::NUM_TARGETS-1:0] buf_empty;
  logic [tnoc_pkg::NUM_TARGETS-1:0] buf_pop;
  logic                             head_ready;
  logic                             fire;
  logic [CNT_W-1:0]                 rsp_cnt;

  tnoc_fifo #(
    .WIDTH ($bits(tnoc_pkg::tnoc_order_t)),
    .DEPTH (ORD_DEPTH                    )
  ) u_ord_fifo (
    .clk      (clk        ),
    .i_arst_n (i_arst_n   ),
    .i_push   (i_ord_valid),
    .i_wdata  (i_ord      ),
    .i_pop    (fire       ),
    .o_rdata  (ord_head   ),
    .o_empty  (ord_empty  )
  );

  for (genvar k = 0; k < tnoc_pkg::NUM_TARGETS; k++) begin : g_rsp_buf
    tnoc_fifo #(
      .WIDTH ($bits(tnoc_pkg::tnoc_response_t)),
      .DEPTH (RSP_BUF_DEPTH                     )
    ) u_rsp_fifo (
      .clk      (clk               ),
      .i_arst_n (i_arst_n          ),
      .i_push   (i_tgt_rsp_valid[k]),
      .i_wdata  (i_tgt_rsp[k]      ),
      .i_pop    (buf_pop[k]        ),
      .o_rdata  (buf_head[k]       ),
      .o_empty  (buf_empty[k]      )
    );
    assign buf_pop[k] = fire && !ord_head.decerr && (ord_head.node == tnoc_pkg::node_id_t'(k));
  end

  // ==========================================================
  // In-order return
  // ==========================================================

  assign head_ready = ord_head.decerr || !buf_empty[ord_head.node];
  assign fire       = !ord_empty && (rsp_cnt != '0) && head_ready;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state   <= MERGE_IDLE;
      rsp_cnt <= CNT_W'(RSP_CREDITS);
    end else begin
      case (state)
        MERGE_IDLE: begin
          if (fire) begin
            state <= MERGE_ISSUE;
          end
        end
        MERGE_ISSUE: begin
          if (!fire) begin
            state <= MERGE_IDLE;  // Back to back issue stays here
          end
        end
        default: state <= MERGE_IDLE;
      endcase
      rsp_cnt <= rsp_cnt - CNT_W'(fire) + CNT_W'(i_rsp_credit);
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      if (ord_head.decerr) begin
        o_rsp.write <= ord_head.write;
        o_rsp.id    <= ord_head.id;
        o_rsp.resp  <= tnoc_pkg::RESP_DECERR;
        o_rsp.rdata <= '0;
      end else begin
        o_rsp <= buf_head[ord_head.node];
      end
    end
  end

  assign o_rsp_valid      = (state == MERGE_ISSUE);
  assign o_ord_credit     = fire;
  assign o_tgt_rsp_credit = buf_pop;
endmodule

//--- verif/tb_tnoc_mem_subsystem.sv
module tb_tnoc_mem_subsystem;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int REQ_FIFO_DEPTH = 4;
  localparam int TGT_FIFO_DEPTH = 2;
  localparam int RSP_BUF_DEPTH  = 2;
  localparam int MEM_WORDS      = 16;
  localparam int RSP_CREDITS    = 2;
  localparam int NUM_REQ        = 200;
  localparam int MAX_CYCLES     = NUM_REQ * 30 + 500;

  logic                     clk;
  logic                     arst_n;
  logic                     req_valid;
  tnoc_pkg::tnoc_request_t  req;
  logic                     rsp_credit;
  logic                     req_credit;
  logic                     rsp_valid;
  tnoc_pkg::tnoc_response_t rsp;

  tnoc_pkg::data_t          model_mem [tnoc_pkg::NUM_TARGETS][MEM_WORDS];
  tnoc_pkg::tnoc_response_t exp_q [$];
  int mismatch_cnt;
  int other_cnt;
  int sent_cnt;
  int recv_cnt;
  int req_credits;        // Request credits the initiator holds
  int rsp_owed;           // Response credits not yet handed back
  int dut_rsp_credits;    // Response credits the DUT holds as seen from here
  int req_credit_pulses;
  int cycles;

  tnoc_mem_subsystem #(
    .REQ_FIFO_DEPTH (REQ_FIFO_DEPTH),
    .TGT_FIFO_DEPTH (TGT_FIFO_DEPTH),
    .RSP_BUF_DEPTH  (RSP_BUF_DEPTH ),
    .MEM_WORDS      (MEM_WORDS     ),
    .RSP_CREDITS    (RSP_CREDITS   )
  ) UUT (
    .clk          (clk       ),
    .i_arst_n     (arst_n    ),
    .i_req_valid  (req_valid ),
    .i_req        (req       ),
    .i_rsp_credit (rsp_credit),
    .o_req_credit (req_credit),
    .o_rsp_valid  (rsp_valid ),
    .o_rsp        (rsp       )
  );

  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH at %0t ns: %s expected 0x%0h actual 0x%0h", $time, name, expected,
               actual);
      mismatch_cnt++;
    end
  endtask

  task automatic build_request(output tnoc_pkg::tnoc_request_t r);
    logic [1:0] region;
    int         word;
    region  = 2'($urandom % 4);
    word    = int'($urandom % MEM_WORDS);
    r.write = 1'($urandom % 2);
    r.id    = tnoc_pkg::txn_id_t'($urandom % 16);
    r.addr  = {region, 14'(word * 4)};  // Word index sits above the two byte offset bits
    r.wdata = $urandom;
  endtask

  // ==========================================================
  // Reference model
  // ==========================================================

  task automatic predict_response(input tnoc_pkg::tnoc_request_t r);
    tnoc_pkg::tnoc_response_t e;
    int region;
    int word;
    region  = int'(r.addr[15:14]);
    word    = int'(r.addr[13:2]) % MEM_WORDS;
    e.write = r.write;
    e.id    = r.id;
    e.resp  = tnoc_pkg::RESP_OKAY;
    e.rdata = '0;
    if (region >= tnoc_pkg::NUM_TARGETS) begin
      e.resp = tnoc_pkg::RESP_DECERR;  // Region 3 has no memory behind it
    end else if (r.write) begin
      model_mem[region][word] = r.wdata;
    end else begin
      e.rdata = model_mem[region][word];
    end
    exp_q.push_back(e);
  endtask

  task automatic check_response();
    tnoc_pkg::tnoc_response_t e;
    if (exp_q.size() == 0) begin
      $display("ERROR at %0t ns: a response arrived with no request outstanding", $time);
      other_cnt++;
    end else begin
      e = exp_q.pop_front();
      check_value("o_rsp.write", 64'(e.write), 64'(rsp.write));
      check_value("o_rsp.id", 64'(e.id), 64'(rsp.id));
      check_value("o_rsp.resp", 64'(e.resp), 64'(rsp.resp));
      check_value("o_rsp.rdata", 64'(e.rdata), 64'(rsp.rdata));
    end
  endtask

  task automatic observe_outputs();
    if (rsp_valid) begin
      check_response();
      recv_cnt++;
      rsp_owed++;
      dut_rsp_credits--;
      if (dut_rsp_credits < 0) begin
        $display("ERROR at %0t ns: response sent without a response credit", $time);
        other_cnt++;
      end
    end
  endtask

  // Credits come back in bursts with withheld stretches in between
  task automatic return_rsp_credit();
    rsp_credit = 1'b0;
    if (rsp_owed > 0 && (cycles % 100) < 60 && ($urandom % 3) == 0) begin
      rsp_credit = 1'b1;
      rsp_owed--;
      dut_rsp_credits++;
    end
  endtask

  // ==========================================================
  // Stimulus and closing report
  // ==========================================================

  initial begin
    tnoc_pkg::tnoc_request_t next_req;
    clk               = 1'b0;
    arst_n            = 1'b0;
    req_valid         = 1'b0;
    req               = '0;
    rsp_credit        = 1'b0;
    mismatch_cnt      = 0;
    other_cnt         = 0;
    sent_cnt          = 0;
    recv_cnt          = 0;
    req_credits       = REQ_FIFO_DEPTH;
    rsp_owed          = 0;
    dut_rsp_credits   = RSP_CREDITS;
    req_credit_pulses = 0;
    cycles            = 0;
    for (int t = 0; t < tnoc_pkg::NUM_TARGETS; t++) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        model_mem[t][w] = '0;
      end
    end
    void'($urandom(22));
    repeat (4) @(negedge clk);
    arst_n = 1'b1;

    while ((sent_cnt < NUM_REQ || recv_cnt < NUM_REQ) && cycles < MAX_CYCLES) begin
      @(negedge clk);
      cycles++;
      observe_outputs();
      req_valid = 1'b0;
      if (sent_cnt < NUM_REQ && req_credits > 0 && ($urandom % 4) != 0) begin
        build_request(next_req);
        predict_response(next_req);
        req       = next_req;
        req_valid = 1'b1;
        req_credits--;
        sent_cnt++;
      end
      if (req_credit) begin
        req_credits++;  // Counted after the send decision of this cycle
        req_credit_pulses++;
      end
      return_rsp_credit();
    end

    if (recv_cnt < NUM_REQ) begin
      $display("ERROR: timeout after %0d cycles with %0d of %0d responses received", cycles,
               recv_cnt, NUM_REQ);
      other_cnt++;
    end

    // Hand back all credits so a duplicated response would show up
    repeat (40) begin
      @(negedge clk);
      cycles++;
      req_valid = 1'b0;
      if (rsp_valid) begin
        $display("ERROR at %0t ns: response arrived after all requests were answered", $time);
        other_cnt++;
      end
      if (req_credit) begin
        req_credit_pulses++;
      end
      rsp_credit = 1'b0;
      if (rsp_owed > 0) begin
        rsp_credit = 1'b1;
        rsp_owed--;
      end
    end
    check_value("o_req_credit pulse count", 64'(sent_cnt), 64'(req_credit_pulses));

    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end
endmodule

//--- verif/tnoc_mem_subsystem_assertions.sv
module tnoc_mem_subsystem_assertions #(
  parameter int RSP_CREDITS = 2
) (
  input logic clk,
  input logic i_arst_n,
  input logic i_rsp_credit,
  input logic o_req_credit,
  input logic o_rsp_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  int held;  // Response credits the subsystem owns at the outside port

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      held <= RSP_CREDITS;
    end else begin
      held <= held - int'(o_rsp_valid) + int'(i_rsp_credit);
    end
  end

  a_rsp_within_credit: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_rsp_valid |-> held > 0)
    else $error("response valid while no response credit is held");

  a_quiet_in_reset: assert property (@(posedge clk)
    !i_arst_n |-> (!o_req_credit && !o_rsp_valid))
    else $error("output active while reset is asserted");

  a_known_outputs: assert property (@(posedge clk) disable iff (!i_arst_n)
    !$isunknown({o_req_credit, o_rsp_valid}))
    else $error("request credit or response valid is unknown");
endmodule

bind tnoc_mem_subsystem tnoc_mem_subsystem_assertions #(
  .RSP_CREDITS (RSP_CREDITS)
) u_assertions (
  .clk          (clk         ),
  .i_arst_n     (i_arst_n    ),
  .i_rsp_credit (i_rsp_credit),
  .o_req_credit (o_req_credit),
  .o_rsp_valid  (o_rsp_valid )
);
